//--- source/iomap_pkg.sv
package iomap_pkg;

   localparam logic [31:0] io_base_addr = 32'h1F80_1000;   // 4 KiB io page

   // memctrl, irq and dma share block 0 and split by slot
   localparam logic [3:0] blk_memctrl = 4'h0;
   localparam logic [3:0] blk_irq     = 4'h0;
   localparam logic [3:0] blk_dma     = 4'h0;
   localparam logic [3:0] blk_gpu     = 4'h8;

   localparam logic [3:0] slot_ram_size = 4'h6;   // 0x60
   localparam logic [3:0] slot_irq      = 4'h7;   // 0x70 stat, 0x74 mask
   localparam logic [3:0] slot_dma0     = 4'h8;   // channel n at 0x80 + 16n
   localparam logic [3:0] slot_dpcr     = 4'hF;   // 0xF0
   localparam logic [1:0] idx_stat      = 2'd0;
   localparam logic [1:0] idx_mask      = 2'd1;

   localparam logic [31:0] gp0_addr = {io_base_addr[31:12], blk_gpu, 8'h10};
   localparam logic [31:0] gp1_addr = {io_base_addr[31:12], blk_gpu, 8'h14};

   localparam int num_mctl    = 9;
   localparam int num_dma_ch  = 7;
   localparam int num_irq     = 11;
   localparam int irq_dma_bit = 3;

   localparam logic [31:0] memctrl_reset [num_mctl] = '{
      32'h1F00_0000, 32'h1F80_2000, 32'h0013_243F,
      32'h0000_3022, 32'h0013_243F, 32'h2009_31E1,
      32'h0002_0843, 32'h0007_0777, 32'h0003_1125
   };
   localparam logic [31:0] ram_size_reset = 32'h0000_0B88;
   localparam logic [31:0] dpcr_reset     = 32'h0765_4321;

   typedef struct packed {
      logic [19:0] page;
      logic [3:0]  blk;
      logic [3:0]  slot;
      logic [1:0]  reg_idx;
      logic [1:0]  byte_off;   // byte lane inside the word
   } io_addr_fields_t;

   typedef union packed {
      logic [31:0]     raw;
      io_addr_fields_t f;
   } io_addr_u;

   typedef struct packed {
      io_addr_u    addr;
      logic [31:0] wdata;
      logic [3:0]  ben;
   } bus_wr_t;

   typedef struct packed {
      logic [31:0] madr;
      logic [31:0] bcr;
      logic [31:0] chcr;
   } dma_chan_t;

   typedef struct packed {
      logic [num_dma_ch-1:0] madr_new;
      logic [num_dma_ch-1:0] madr_incr;
      logic [num_dma_ch-1:0] madr_decr;
      logic [num_dma_ch-1:0] bcr_decr;
      logic [num_dma_ch-1:0] irq;
   } dma_upd_t;

   typedef enum logic [3:0] {
      st_idle  = 4'b0001,
      st_read  = 4'b0010,
      st_write = 4'b0100,
      st_done  = 4'b1000
   } ctrl_state_t;

   // replace the enabled byte lanes of a register word
   function automatic logic [31:0] ben_merge(input logic [31:0] old_w,
                                             input logic [31:0] new_w,
                                             input logic [3:0]  ben);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (ben[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

endpackage

//--- source/bus_ctrl.sv
`timescale 1ns/100ps

module bus_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               req_i,
   input  logic               we_i,
   input  iomap_pkg::bus_wr_t req_i_fields,
   input  logic [31:0]        mem_rdata_i,
   input  logic [31:0]        dma_rdata_i,
   input  logic [31:0]        irq_rdata_i,
   input  logic [31:0]        gpu_rdata_i,
   input  logic               gp_done_i,
   output iomap_pkg::bus_wr_t wr_o,
   output logic               mem_we_o,
   output logic               dma_we_o,
   output logic               irq_we_o,
   output logic               gp_wr_o,
   output logic               gp_rd_o,
   output logic               ack_o,
   output logic [31:0]        rdata_o
);

   iomap_pkg::ctrl_state_t state_q;
   iomap_pkg::ctrl_state_t state_d;
   iomap_pkg::bus_wr_t     wr_q;         // request held for the whole transfer
   logic        first_q;                 // first cycle of read or write state
   logic        page_hit;
   logic        mem_hit;
   logic        irq_hit;
   logic        dma_hit;
   logic        gp0_hit;
   logic        gp1_hit;
   logic        gp_wait;
   logic        wr_stb;
   logic        rd_stb;
   logic [31:0] rd_word;

   assign page_hit = wr_q.addr.raw[31:12] == iomap_pkg::io_base_addr[31:12];
   assign mem_hit  = page_hit && wr_q.addr.f.blk == iomap_pkg::blk_memctrl &&
                     (wr_q.addr.f.slot < 4'h3 ||
                      wr_q.addr.f.slot == iomap_pkg::slot_ram_size);
   assign irq_hit  = page_hit && wr_q.addr.f.blk == iomap_pkg::blk_irq &&
                     wr_q.addr.f.slot == iomap_pkg::slot_irq &&
                     (wr_q.addr.f.reg_idx == iomap_pkg::idx_stat ||
                      wr_q.addr.f.reg_idx == iomap_pkg::idx_mask);
   assign dma_hit  = page_hit && wr_q.addr.f.blk == iomap_pkg::blk_dma &&
                     wr_q.addr.f.slot >= iomap_pkg::slot_dma0;
   assign gp0_hit  = wr_q.addr.raw == iomap_pkg::gp0_addr;
   assign gp1_hit  = wr_q.addr.raw == iomap_pkg::gp1_addr;

   // GP0 push and GPUREAD capture hold the state until the port reports done
   assign gp_wait = gp0_hit && !(gp_done_i && !first_q);

   assign wr_stb   = first_q && state_q == iomap_pkg::st_write;
   assign rd_stb   = first_q && state_q == iomap_pkg::st_read;
   assign mem_we_o = wr_stb && mem_hit;
   assign dma_we_o = wr_stb && dma_hit;
   assign irq_we_o = wr_stb && irq_hit;
   assign gp_wr_o  = wr_stb && (gp0_hit || gp1_hit);
   assign gp_rd_o  = rd_stb && gp0_hit;    // GPUSTAT needs no handshake

   assign ack_o = state_q == iomap_pkg::st_done;
   assign wr_o  = wr_q;

   always_comb begin
      if (mem_hit) rd_word = mem_rdata_i;
      else if (dma_hit) rd_word = dma_rdata_i;
      else if (irq_hit) rd_word = irq_rdata_i;
      else if (gp0_hit || gp1_hit) rd_word = gpu_rdata_i;
      else rd_word = 32'd0;   // unmapped
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         iomap_pkg::st_idle: begin
            if (req_i) state_d = we_i ? iomap_pkg::st_write : iomap_pkg::st_read;
         end
         iomap_pkg::st_read, iomap_pkg::st_write: begin
            if (!gp_wait) state_d = iomap_pkg::st_done;
         end
         iomap_pkg::st_done: begin
            if (!req_i) state_d = iomap_pkg::st_idle;   // four-phase release
         end
         default: state_d = iomap_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state_q <= iomap_pkg::st_idle;
         first_q <= 1'b0;
         rdata_o <= 32'd0;
      end else begin
         state_q <= state_d;
         first_q <= state_q == iomap_pkg::st_idle && req_i;
         if (state_q == iomap_pkg::st_read && !gp_wait) rdata_o <= rd_word;
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == iomap_pkg::st_idle && req_i) wr_q <= req_i_fields;
   end

   a_ack_hold: assert property (@(posedge clk) disable iff (rst)
      ack_o && req_i |=> ack_o)
      else $error("ack_o fell while req_i still high");

   a_one_stb: assert property (@(posedge clk) disable iff (rst)
      $onehot0({mem_we_o, dma_we_o, irq_we_o, gp_wr_o}))
      else $error("more than one write strobe active");

endmodule

//--- source/memctrl_regs.sv
`timescale 1ns/100ps

module memctrl_regs (
   input  logic               clk,
   input  logic               rst,
   input  iomap_pkg::bus_wr_t wr_i,
   input  logic               we_i,
   output logic [31:0]        rdata_o
);

   logic [31:0] mctl_q [iomap_pkg::num_mctl];
   logic [31:0] ram_size_q;
   logic [3:0]  widx;        // word number from offset 0x00
   logic        mctl_sel;
   logic        ram_sel;

   assign widx     = {wr_i.addr.f.slot[1:0], wr_i.addr.f.reg_idx};
   assign mctl_sel = wr_i.addr.f.slot < 4'h3 && int'(widx) < iomap_pkg::num_mctl;
   assign ram_sel  = wr_i.addr.f.slot == iomap_pkg::slot_ram_size &&
                     wr_i.addr.f.reg_idx == 2'd0;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         for (int i = 0; i < iomap_pkg::num_mctl; i++) begin
            mctl_q[i] <= iomap_pkg::memctrl_reset[i];   // console boot values
         end
         ram_size_q <= iomap_pkg::ram_size_reset;
      end else if (we_i) begin
         if (mctl_sel) begin
            mctl_q[widx] <= iomap_pkg::ben_merge(mctl_q[widx], wr_i.wdata, wr_i.ben);
         end
         if (ram_sel) begin
            ram_size_q <= iomap_pkg::ben_merge(ram_size_q, wr_i.wdata, wr_i.ben);
         end
      end
   end

   always_comb begin
      if (mctl_sel) rdata_o = mctl_q[widx];
      else if (ram_sel) rdata_o = ram_size_q;
      else rdata_o = 32'd0;
   end

endmodule

//--- source/dma_regs.sv
`timescale 1ns/100ps

module dma_regs (
   input  logic                                              clk,
   input  logic                                              rst,
   input  iomap_pkg::bus_wr_t                                wr_i,
   input  logic                                              we_i,
   input  iomap_pkg::dma_upd_t                               upd_i,
   input  logic [iomap_pkg::num_dma_ch-1:0][31:0]            madr_i,
   output logic [31:0]                                       rdata_o,
   output iomap_pkg::dma_chan_t [iomap_pkg::num_dma_ch-1:0]  chan_o,
   output logic [31:0]                                       dpcr_o
);

   iomap_pkg::dma_chan_t [iomap_pkg::num_dma_ch-1:0] chan_q;
   logic [31:0] dpcr_q;
   logic [3:0]  ch_off;
   logic [2:0]  ch;
   logic        ch_sel;       // MADR, BCR or CHCR of channels 0..6
   logic        dpcr_sel;

   assign ch_off   = wr_i.addr.f.slot - iomap_pkg::slot_dma0;
   assign ch       = ch_off[2:0];
   assign ch_sel   = wr_i.addr.f.slot >= iomap_pkg::slot_dma0 &&
                     wr_i.addr.f.slot != iomap_pkg::slot_dpcr &&
                     wr_i.addr.f.reg_idx != 2'd3;
   assign dpcr_sel = wr_i.addr.f.slot == iomap_pkg::slot_dpcr &&
                     wr_i.addr.f.reg_idx == 2'd0;

   assign chan_o = chan_q;
   assign dpcr_o = dpcr_q;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         chan_q <= '0;
         dpcr_q <= iomap_pkg::dpcr_reset;
      end else if (we_i) begin
         // cpu write wins over all engine requests
         if (dpcr_sel) dpcr_q <= iomap_pkg::ben_merge(dpcr_q, wr_i.wdata, wr_i.ben);
         if (ch_sel) begin
            case (wr_i.addr.f.reg_idx)
               2'd0: chan_q[ch].madr <=
                  iomap_pkg::ben_merge(chan_q[ch].madr, wr_i.wdata, wr_i.ben);
               2'd1: chan_q[ch].bcr <=
                  iomap_pkg::ben_merge(chan_q[ch].bcr, wr_i.wdata, wr_i.ben);
               default: chan_q[ch].chcr <=
                  iomap_pkg::ben_merge(chan_q[ch].chcr, wr_i.wdata, wr_i.ben);
            endcase
         end
      end else begin
         for (int c = 0; c < iomap_pkg::num_dma_ch; c++) begin
            if (upd_i.madr_new[c]) chan_q[c].madr <= madr_i[c];
            else if (upd_i.madr_decr[c]) chan_q[c].madr <= chan_q[c].madr - 32'd4;
            else if (upd_i.madr_incr[c]) chan_q[c].madr <= chan_q[c].madr + 32'd4;
            if (upd_i.bcr_decr[c]) begin
               chan_q[c].bcr[31:16] <= chan_q[c].bcr[31:16] - 16'd1;   // block count
            end
         end
      end
   end

   always_comb begin
      rdata_o = 32'd0;
      if (dpcr_sel) rdata_o = dpcr_q;
      else if (ch_sel) begin
         case (wr_i.addr.f.reg_idx)
            2'd0:    rdata_o = chan_q[ch].madr;
            2'd1:    rdata_o = chan_q[ch].bcr;
            default: rdata_o = chan_q[ch].chcr;
         endcase
      end
   end

   a_madr_dir: assert property (@(posedge clk) disable iff (rst)
      (upd_i.madr_incr & upd_i.madr_decr) == '0)
      else $error("DMA engine requested MADR increment and decrement together");

endmodule

//--- source/irq_regs.sv
`timescale 1ns/100ps

module irq_regs (
   input  logic                               clk,
   input  logic                               rst,
   input  iomap_pkg::bus_wr_t                 wr_i,
   input  logic                               we_i,
   input  logic [iomap_pkg::num_irq-1:0]      src_i,
   input  logic [iomap_pkg::num_dma_ch-1:0]   dma_irq_i,
   output logic [31:0]                        rdata_o,
   output logic [iomap_pkg::num_irq-1:0]      interrupts_o
);

   logic [iomap_pkg::num_irq-1:0] stat_q;
   logic [iomap_pkg::num_irq-1:0] mask_q;
   logic [iomap_pkg::num_irq-1:0] set_v;
   logic [iomap_pkg::num_irq-1:0] keep_v;
   logic [31:0] keep_w;      // zero where a written lane holds a zero
   logic [31:0] mask_w;
   logic        stat_sel;
   logic        mask_sel;

   assign stat_sel = wr_i.addr.f.reg_idx == iomap_pkg::idx_stat;
   assign mask_sel = wr_i.addr.f.reg_idx == iomap_pkg::idx_mask;
   assign keep_w   = iomap_pkg::ben_merge('1, wr_i.wdata, wr_i.ben);
   assign mask_w   = iomap_pkg::ben_merge(32'(mask_q), wr_i.wdata, wr_i.ben);
   assign keep_v   = (we_i && stat_sel) ? keep_w[iomap_pkg::num_irq-1:0] : '1;

   always_comb begin
      set_v = src_i;
      set_v[iomap_pkg::irq_dma_bit] = src_i[iomap_pkg::irq_dma_bit] | (|dma_irq_i);
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         stat_q <= '0;
         mask_q <= '0;
      end else begin
         stat_q <= (stat_q & keep_v) | set_v;   // new events win over the clear
         if (we_i && mask_sel) mask_q <= mask_w[iomap_pkg::num_irq-1:0];
      end
   end

   assign interrupts_o = stat_q & mask_q;

   always_comb begin
      if (stat_sel) rdata_o = 32'(stat_q);
      else if (mask_sel) rdata_o = 32'(mask_q);
      else rdata_o = 32'd0;
   end

endmodule

//--- source/gpu_port.sv
`timescale 1ns/100ps

module gpu_port (
   input  logic               clk,
   input  logic               rst,
   input  iomap_pkg::bus_wr_t wr_i,
   input  logic               gp_wr_i,
   input  logic               gp_rd_i,
   input  logic               fifo_full_i,
   input  logic               rdy_i,
   input  logic [31:0]        read_i,
   input  logic [31:0]        stat_i,
   output logic [31:0]        gp0_o,
   output logic [31:0]        gp1_o,
   output logic               to_gp0_o,
   output logic               to_gp1_o,
   output logic               ren_o,
   output logic [31:0]        rdata_o,
   output logic               done_o
);

   logic        is_gp1;
   logic        pend0_q;     // GP0 command waiting for FIFO room
   logic        rd_pend_q;   // GPUREAD waiting for ready
   logic        to_gp1_q;
   logic        ren_q;
   logic [31:0] cmd_q;
   logic [31:0] read_q;

   assign is_gp1 = wr_i.addr.raw == iomap_pkg::gp1_addr;

   assign to_gp0_o = pend0_q && !fifo_full_i;
   assign to_gp1_o = to_gp1_q;
   assign gp0_o    = cmd_q;
   assign gp1_o    = cmd_q;
   assign ren_o    = ren_q;
   assign done_o   = to_gp0_o || to_gp1_q || ren_q;
   assign rdata_o  = is_gp1 ? stat_i : read_q;   // GPUSTAT passes straight through

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pend0_q   <= 1'b0;
         rd_pend_q <= 1'b0;
         to_gp1_q  <= 1'b0;
         ren_q     <= 1'b0;
      end else begin
         pend0_q   <= (pend0_q && fifo_full_i) || (gp_wr_i && !is_gp1);
         to_gp1_q  <= gp_wr_i && is_gp1;       // GP1 never stalls
         rd_pend_q <= (rd_pend_q && !rdy_i) || gp_rd_i;
         ren_q     <= rd_pend_q && rdy_i;
      end
   end

   always_ff @(posedge clk) begin
      if (gp_wr_i) cmd_q <= wr_i.wdata;
      if (rd_pend_q && rdy_i) read_q <= read_i;
   end

   a_no_push_full: assert property (@(posedge clk) disable iff (rst)
      to_gp0_o |-> !fifo_full_i)
      else $error("GP0 push into a full FIFO");

endmodule

//--- source/io_controller.sv
`timescale 1ns/100ps

module io_controller (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic                                              req_i,
   input  logic                                              we_i,
   input  logic [31:0]                                       addr_i,
   input  logic [31:0]                                       wdata_i,
   input  logic [3:0]                                        ben_i,
   output logic                                              ack_o,
   output logic [31:0]                                       rdata_o,
   input  iomap_pkg::dma_upd_t                               dma_upd_i,
   input  logic [iomap_pkg::num_dma_ch-1:0][31:0]            dma_madr_i,
   output iomap_pkg::dma_chan_t [iomap_pkg::num_dma_ch-1:0]  dma_chan_o,
   output logic [31:0]                                       dpcr_o,
   output logic [31:0]                                       gp0_o,
   output logic [31:0]                                       gp1_o,
   output logic                                              to_gp0_o,
   output logic                                              to_gp1_o,
   input  logic                                              gpu_fifo_full_i,
   input  logic                                              gpu_rdy_i,
   output logic                                              gpu_ren_o,
   input  logic [31:0]                                       gpu_read_i,
   input  logic [31:0]                                       gpu_stat_i,
   input  logic [iomap_pkg::num_irq-1:0]                     irq_src_i,
   output logic [iomap_pkg::num_irq-1:0]                     interrupts_o
);

   iomap_pkg::bus_wr_t req_w;
   iomap_pkg::bus_wr_t wr_w;     // held request seen by all blocks
   logic        mem_we;
   logic        dma_we;
   logic        irq_we;
   logic        gp_wr;
   logic        gp_rd;
   logic        gp_done;
   logic [31:0] mem_rdata;
   logic [31:0] dma_rdata;
   logic [31:0] irq_rdata;
   logic [31:0] gpu_rdata;

   assign req_w = {addr_i, wdata_i, ben_i};

   bus_ctrl u_bus_ctrl (
      .clk(clk), .rst(rst), .req_i(req_i), .we_i(we_i), .req_i_fields(req_w),
      .mem_rdata_i(mem_rdata), .dma_rdata_i(dma_rdata), .irq_rdata_i(irq_rdata),
      .gpu_rdata_i(gpu_rdata), .gp_done_i(gp_done), .wr_o(wr_w),
      .mem_we_o(mem_we), .dma_we_o(dma_we), .irq_we_o(irq_we),
      .gp_wr_o(gp_wr), .gp_rd_o(gp_rd), .ack_o(ack_o), .rdata_o(rdata_o)
   );

   memctrl_regs u_memctrl_regs (
      .clk(clk), .rst(rst), .wr_i(wr_w), .we_i(mem_we), .rdata_o(mem_rdata)
   );

   dma_regs u_dma_regs (
      .clk(clk), .rst(rst), .wr_i(wr_w), .we_i(dma_we), .upd_i(dma_upd_i),
      .madr_i(dma_madr_i), .rdata_o(dma_rdata), .chan_o(dma_chan_o), .dpcr_o(dpcr_o)
   );

   irq_regs u_irq_regs (
      .clk(clk), .rst(rst), .wr_i(wr_w), .we_i(irq_we), .src_i(irq_src_i),
      .dma_irq_i(dma_upd_i.irq), .rdata_o(irq_rdata), .interrupts_o(interrupts_o)
   );

   gpu_port u_gpu_port (
      .clk(clk), .rst(rst), .wr_i(wr_w), .gp_wr_i(gp_wr), .gp_rd_i(gp_rd),
      .fifo_full_i(gpu_fifo_full_i), .rdy_i(gpu_rdy_i), .read_i(gpu_read_i),
      .stat_i(gpu_stat_i), .gp0_o(gp0_o), .gp1_o(gp1_o), .to_gp0_o(to_gp0_o),
      .to_gp1_o(to_gp1_o), .ren_o(gpu_ren_o), .rdata_o(gpu_rdata), .done_o(gp_done)
   );

endmodule

//--- tests/tb_io_controller.sv
`timescale 1ns/100ps

module tb_io_controller;

   localparam int stim_depth = 64;
   localparam logic [31:0] gp0_adr = 32'h1F80_1810;   // GP0 write, GPUREAD read

   logic        clk;
   logic        rst;
   logic        req_i;
   logic        we_i;
   logic [31:0] addr_i;
   logic [31:0] wdata_i;
   logic [3:0]  ben_i;
   logic        ack_o;
   logic [31:0] rdata_o;
   iomap_pkg::dma_upd_t dma_upd_i;
   logic [iomap_pkg::num_dma_ch-1:0][31:0] dma_madr_i;
   iomap_pkg::dma_chan_t [iomap_pkg::num_dma_ch-1:0] dma_chan_o;
   logic [31:0] dpcr_o;
   logic [31:0] gp0_o;
   logic [31:0] gp1_o;
   logic        to_gp0_o;
   logic        to_gp1_o;
   logic        gpu_fifo_full_i;
   logic        gpu_rdy_i;
   logic        gpu_ren_o;
   logic [31:0] gpu_read_i;
   logic [31:0] gpu_stat_i;
   logic [iomap_pkg::num_irq-1:0] irq_src_i;
   logic [iomap_pkg::num_irq-1:0] interrupts_o;

   logic [103:0] stim [stim_depth];   // op, a, b, c
   int          n_ops;
   int          val_errs;
   int          proto_errs;
   int          push_errs;
   int          gp0_cnt;
   int          gp1_cnt;
   int          ren_cnt;
   logic [31:0] gp0_last;
   logic [31:0] gp1_last;
   logic [31:0] rnd;
   int          stall_cnt;
   logic        stall_next;
   logic        req_seen;

   io_controller DUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] rand_step(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
         val_errs++;
      end
   endtask

   // four-phase transfer with optional DMA engine requests in the strobe cycle
   task automatic bus_xfer(input logic we, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] ben, input logic collide,
                           output logic [31:0] rd);
      int   cyc;
      logic acked;
      cyc = -1;
      acked = 1'b0;
      rd = '0;
      @(posedge clk);
      req_i <= 1'b1;
      we_i <= we;
      addr_i <= addr;
      wdata_i <= data;
      ben_i <= ben;
      while (!acked && cyc < 40) begin
         @(negedge clk);
         cyc++;
         if (ack_o) acked = 1'b1;
         else begin
            @(posedge clk);
            if (collide && cyc == 0) begin
               dma_upd_i.madr_incr <= '1;   // every channel asks at once
               dma_upd_i.bcr_decr <= '1;
            end else begin
               dma_upd_i <= '0;
            end
         end
      end
      if (!acked) begin
         $display("no ack_o within 40 cycles of the request to %h", addr);
         proto_errs++;
      end else if (addr != gp0_adr && cyc != 2) begin
         $display("ack_o came %0d cycles after the request to %h instead of 2", cyc, addr);
         proto_errs++;
      end
      rd = rdata_o;
      @(posedge clk);   // req still held one more cycle
      @(negedge clk);
      if (!ack_o) begin
         $display("ack_o fell while req_i was still high");
         proto_errs++;
      end
      @(posedge clk);
      req_i <= 1'b0;
      we_i <= 1'b0;
      @(negedge clk);
      if (!ack_o) begin
         $display("ack_o fell before the slave saw req_i low");
         proto_errs++;
      end
      @(negedge clk);
      if (ack_o) begin
         $display("ack_o still high a cycle after req_i fell");
         proto_errs++;
      end
   endtask

   task automatic dma_request(input int ch, input int kind, input logic [31:0] word);
      if (ch >= iomap_pkg::num_dma_ch || kind > 4) begin
         $display("bad DMA request in stim, channel %0d kind %0d", ch, kind);
         proto_errs++;
         return;
      end
      @(posedge clk);
      case (kind)
         0: begin
            dma_madr_i[ch] <= word;
            dma_upd_i.madr_new[ch] <= 1'b1;
         end
         1: dma_upd_i.madr_incr[ch] <= 1'b1;
         2: dma_upd_i.madr_decr[ch] <= 1'b1;
         3: dma_upd_i.bcr_decr[ch] <= 1'b1;
         default: dma_upd_i.irq[ch] <= 1'b1;
      endcase
      @(posedge clk);
      dma_upd_i <= '0;
      @(negedge clk);
   endtask

   task automatic pulse_irq(input logic [iomap_pkg::num_irq-1:0] bits);
      @(posedge clk);
      irq_src_i <= bits;
      @(posedge clk);
      irq_src_i <= '0;
      @(negedge clk);
   endtask

   // index ch*3+reg for channel words, 21 dpcr_o, 22 interrupts_o, 255 all channel words
   task automatic check_outputs(input int idx, input logic [31:0] exp);
      int c;
      if (idx == 255) begin
         for (c = 0; c < iomap_pkg::num_dma_ch; c++) begin
            check_word($sformatf("dma_chan_o[%0d].madr", c), dma_chan_o[c].madr, exp);
            check_word($sformatf("dma_chan_o[%0d].bcr", c), dma_chan_o[c].bcr, exp);
            check_word($sformatf("dma_chan_o[%0d].chcr", c), dma_chan_o[c].chcr, exp);
         end
      end else if (idx < 3 * iomap_pkg::num_dma_ch) begin
         c = idx / 3;
         case (idx % 3)
            0: check_word($sformatf("dma_chan_o[%0d].madr", c), dma_chan_o[c].madr, exp);
            1: check_word($sformatf("dma_chan_o[%0d].bcr", c), dma_chan_o[c].bcr, exp);
            default: check_word($sformatf("dma_chan_o[%0d].chcr", c), dma_chan_o[c].chcr, exp);
         endcase
      end else if (idx == 21) begin
         check_word("dpcr_o", dpcr_o, exp);
      end else if (idx == 22) begin
         check_word("interrupts_o", 32'(interrupts_o), exp);
      end else begin
         $display("unknown output index %0d in stim", idx);
         proto_errs++;
      end
   endtask

   task automatic run_op(input logic [103:0] e);
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] rd;
      int          r0;
      int          p0;
      int          p1;
      op = e[103:96];
      a = e[95:64];
      b = e[63:32];
      c = e[31:0];
      case (op)
         8'h01: bus_xfer(1'b1, a, b, c[3:0], 1'b0, rd);
         8'h08: bus_xfer(1'b1, a, b, c[3:0], 1'b1, rd);
         8'h02: begin
            r0 = ren_cnt;
            bus_xfer(1'b0, a, '0, 4'h0, 1'b0, rd);
            check_word($sformatf("rdata_o at %h", a), rd, b);
            if (ren_cnt - r0 != ((a == gp0_adr) ? 1 : 0)) begin
               $display("read of %h gave %0d gpu_ren_o pulses", a, ren_cnt - r0);
               proto_errs++;
            end
         end
         8'h03: dma_request(int'(a[7:0]), int'(b[7:0]), c);
         8'h04: pulse_irq(a[iomap_pkg::num_irq-1:0]);
         8'h05: begin
            p0 = gp0_cnt;
            p1 = gp1_cnt;
            bus_xfer(1'b1, a, b, 4'hF, 1'b0, rd);
            if (a == gp0_adr) begin
               if (gp0_cnt - p0 != 1 || gp1_cnt != p1) begin
                  $display("GP0 write gave %0d GP0 and %0d GP1 pushes",
                           gp0_cnt - p0, gp1_cnt - p1);
                  proto_errs++;
               end
               check_word("gp0_o", gp0_last, b);
            end else begin
               if (gp1_cnt - p1 != 1 || gp0_cnt != p0) begin
                  $display("GP1 write gave %0d GP1 and %0d GP0 pushes",
                           gp1_cnt - p1, gp0_cnt - p0);
                  proto_errs++;
               end
               check_word("gp1_o", gp1_last, b);
            end
         end
         8'h06: check_outputs(int'(a[7:0]), b);
         8'h07: begin
            @(posedge clk);
            gpu_read_i <= a;
            gpu_stat_i <= b;
         end
         default: begin
            $display("unknown stim op %h", op);
            proto_errs++;
         end
      endcase
   endtask

   // GPU model counts pushes and arms a random stall at each new request
   initial begin
      gp0_cnt = 0;
      gp1_cnt = 0;
      ren_cnt = 0;
      push_errs = 0;
      gp0_last = '0;
      gp1_last = '0;
      rnd = 32'd54992;
      stall_cnt = 0;
      stall_next = 1'b0;
      req_seen = 1'b0;
      forever begin
         @(negedge clk);
         if (!rst) begin
            if (to_gp0_o) begin
               gp0_cnt++;
               gp0_last = gp0_o;
               if (gpu_fifo_full_i) begin
                  $display("GP0 push while the GPU FIFO was full");
                  push_errs++;
               end
            end
            if (to_gp1_o) begin
               gp1_cnt++;
               gp1_last = gp1_o;
            end
            if (gpu_ren_o) ren_cnt++;
         end
         if (req_i && !req_seen) begin
            rnd = rand_step(rnd);
            stall_cnt = int'(rnd[1:0]) + 1;
         end
         req_seen = req_i;
         stall_next = stall_cnt > 1;   // the first count only covers the request cycle
         if (stall_cnt != 0) stall_cnt--;
      end
   end

   initial begin
      gpu_fifo_full_i = 1'b0;
      gpu_rdy_i = 1'b1;
      forever begin
         @(posedge clk);
         gpu_fifo_full_i <= stall_next;
         gpu_rdy_i <= !stall_next;
      end
   end

   initial begin
      #1;
      repeat ((n_ops + 2) * 20) @(posedge clk);
      $display("watchdog expired after %0d cycles", (n_ops + 2) * 20);
      $display("errors: %0d value, %0d protocol, %0d push", val_errs, proto_errs, push_errs);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      rst = 1'b1;
      req_i = 1'b0;
      we_i = 1'b0;
      addr_i = '0;
      wdata_i = '0;
      ben_i = '0;
      dma_upd_i = '0;
      dma_madr_i = '0;
      gpu_read_i = '0;
      gpu_stat_i = '0;
      irq_src_i = '0;
      val_errs = 0;
      proto_errs = 0;
      $readmemh("tests/io_stim.txt", stim);
      n_ops = 0;
      while (n_ops < stim_depth && stim[n_ops][103:96] !== 8'hFF) n_ops++;
      if (n_ops == stim_depth) begin
         $display("stim file has no end marker");
         proto_errs++;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      if (ack_o || to_gp0_o || to_gp1_o || gpu_ren_o) begin
         $display("a handshake output is high after reset");
         proto_errs++;
      end
      check_word("rdata_o", rdata_o, '0);
      check_word("interrupts_o", 32'(interrupts_o), '0);
      for (int i = 0; i < n_ops; i++) begin
         run_op(stim[i]);
      end
      repeat (2) @(posedge clk);
      $display("errors: %0d value, %0d protocol, %0d push", val_errs, proto_errs, push_errs);
      if (val_errs + proto_errs + push_errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- tests/io_stim.txt
// op_a_b_c: 01 write addr data ben, 02 read addr expect, 03 dma ch kind word, 04 irq bits,
// 05 gpu write addr data, 06 check idx expect, 07 gpu read stat, 08 write vs dma, FF end
02_1F801000_1F000000_00000000
02_1F801004_1F802000_00000000
02_1F801008_0013243F_00000000
02_1F80100C_00003022_00000000
02_1F801010_0013243F_00000000
02_1F801014_200931E1_00000000
02_1F801018_00020843_00000000
02_1F80101C_00070777_00000000
02_1F801020_00031125_00000000
02_1F801060_00000B88_00000000
02_1F8010F0_07654321_00000000
06_00000015_07654321_00000000
06_000000FF_00000000_00000000
02_1F8010A4_00000000_00000000
01_1F801008_AABBCCDD_00000005
02_1F801008_00BB24DD_00000000
01_1F801060_FFFFFFFF_00000002
02_1F801060_0000FF88_00000000
01_1F801090_80001000_0000000F
01_1F801094_00030010_0000000F
06_00000003_80001000_00000000
06_00000004_00030010_00000000
03_00000001_00000001_00000000
03_00000001_00000001_00000000
03_00000001_00000002_00000000
03_00000001_00000003_00000000
02_1F801090_80001004_00000000
02_1F801094_00020010_00000000
03_00000004_00000000_00200000
06_0000000C_00200000_00000000
08_1F8010C0_00ABCDEF_0000000F
06_0000000C_00ABCDEF_00000000
06_00000003_80001004_00000000
06_00000004_00020010_00000000
01_1F801074_00000109_0000000F
04_00000101_00000000_00000000
03_00000005_00000004_00000000
02_1F801070_00000109_00000000
06_00000016_00000109_00000000
04_00000002_00000000_00000000
06_00000016_00000109_00000000
01_1F801070_FFFFFEFE_0000000F
02_1F801070_0000000A_00000000
06_00000016_00000008_00000000
07_CAFE0001_14802000_00000000
05_1F801810_E1000123_00000000
05_1F801814_08000009_00000000
05_1F801810_A0000000_00000000
02_1F801810_CAFE0001_00000000
02_1F801814_14802000_00000000
02_1F801050_00000000_00000000
02_00001000_00000000_00000000
FF_00000000_00000000_00000000

//--- sources.f
source/iomap_pkg.sv
source/bus_ctrl.sv
source/memctrl_regs.sv
source/dma_regs.sv
source/irq_regs.sv
source/gpu_port.sv
source/io_controller.sv
tests/tb_io_controller.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_io_controller \
   --Mdir obj_dir -o tb_io_controller
./obj_dir/tb_io_controller > sim.log
cat sim.log
if grep -q "^STATUS: PASS$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
